/* tb.f */
design/StoreCommitPkg.sv
design/StoreQueueIF.sv
design/StoreAllocator.sv
design/StoreQueue.sv
design/StoreCommitter.sv
design/DataCache.sv
design/StoreSubsystem.sv
verification/StoreSubsystemTb.sv

/* run.sh */
#!/bin/bash
# Build the store subsystem testbench with Verilator and run it.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f tb.f \
        --top-module StoreSubsystemTb \
    && ./obj_dir/VStoreSubsystemTb | tee /dev/stderr | grep -q "Everything OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verification/StoreSubsystemTb.sv */
// ----------------------------------------------------------------------
// Store subsystem testbench
// Drives random stores, commits and recoveries into the store side and
// checks memory, IO writes and status flags against a byte model.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module StoreSubsystemTb import StoreCommitPkg::*; ();

    localparam logic [9:0] IO_START = 10'h3C0;
    localparam int CACHEABLE_WORDS = 240;
    localparam int DRAIN_TIMEOUT = 300;

    logic clk = 1'b0;
    logic rstN;
    logic storeValid;
    logic [9:0] storeAddr;
    AccessSize storeSize;
    logic [31:0] storeData;
    logic sqFull;
    logic commitStore;
    CommitCount commitStoreNum;
    logic recover;
    logic busyInRecovery;
    logic ioWe;
    logic [7:0] ioAddr;
    logic [31:0] ioData;
    logic [9:0] loadAddr;
    logic [31:0] loadData;

    integer seed = 77;
    int errorCount = 0;
    int checkCount = 0;
    int committedCount = 0;
    int releaseCount;

    // Byte image of memory, and the stores the model still waits on.
    logic [7:0] refMem [1024];
    logic [9:0] issAddr [$];
    AccessSize issSize [$];
    logic [31:0] issData [$];
    logic [7:0] expIoAddr [$];
    logic [31:0] expIoData [$];

    StoreSubsystem i_dut (
        .clk            (clk),
        .rstN           (rstN),
        .storeValid     (storeValid),
        .storeAddr      (storeAddr),
        .storeSize      (storeSize),
        .storeData      (storeData),
        .sqFull         (sqFull),
        .commitStore    (commitStore),
        .commitStoreNum (commitStoreNum),
        .recover        (recover),
        .busyInRecovery (busyInRecovery),
        .ioWe           (ioWe),
        .ioAddr         (ioAddr),
        .ioData         (ioData),
        .loadAddr       (loadAddr),
        .loadData       (loadData)
    );

    always #10 clk = ~clk;

    // Every release pulse finishes one committed store.
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            releaseCount <= 0;
        end else if (i_dut.sqIf.releaseHead) begin
            releaseCount <= releaseCount + 1;
        end
    end

    assert property (@(negedge clk) disable iff (!rstN) recover |=> busyInRecovery)
        else begin
            errorCount++;
            $display("FAIL %0t: busyInRecovery did not follow recover", $time);
        end

    assert property (@(negedge clk) disable iff (!rstN) busyInRecovery |-> $past(recover))
        else begin
            errorCount++;
            $display("FAIL %0t: busyInRecovery high without a recover pulse", $time);
        end

    // IO writes must match committed IO stores, oldest first.
    always @(negedge clk) begin
        if (rstN && ioWe) begin
            checkCount++;
            assert (expIoAddr.size() != 0) else begin
                errorCount++;
                $display("FAIL %0t: ioWe at %h with no committed IO store", $time, ioAddr);
            end
            if (expIoAddr.size() != 0) begin
                assert (ioAddr == expIoAddr[0] && ioData == expIoData[0]) else begin
                    errorCount++;
                    $display("FAIL %0t: IO write %h/%h, expected %h/%h", $time,
                             ioAddr, ioData, expIoAddr[0], expIoData[0]);
                end
                void'(expIoAddr.pop_front());
                void'(expIoData.pop_front());
            end
        end
    end

    // Aligns the oldest issued stores and applies them to the model.
    task automatic retireModel(input int n);
        logic [9:0] addr;
        AccessSize size;
        logic [31:0] data;
        logic [3:0] be;
        logic [31:0] aligned;
        int lane;
        for (int k = 0; k < n; k++) begin
            addr = issAddr.pop_front();
            size = issSize.pop_front();
            data = issData.pop_front();
            lane = int'(addr[1:0]);
            case (size)
                SIZE_BYTE: be = 4'b0001;
                SIZE_HALF: begin
                    be = 4'b0011;
                    lane = lane & 2;
                end
                default: begin
                    be = 4'b1111;
                    lane = 0;
                end
            endcase
            aligned = '0;
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    aligned[8*(b+lane) +: 8] = data[8*b +: 8];
                end
            end
            be = be << lane;
            if (addr >= IO_START) begin
                expIoAddr.push_back(addr[9:2]);
                expIoData.push_back(aligned);
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        refMem[{addr[9:2], 2'(b)}] = aligned[8*b +: 8];
                    end
                end
            end
        end
        committedCount += n;
    endtask

    task automatic driveIdle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            storeValid <= 1'b0;
            commitStore <= 1'b0;
            recover <= 1'b0;
        end
    endtask

    task automatic driveStore(input logic [9:0] addr, input AccessSize size,
                              input logic [31:0] data);
        @(posedge clk);
        storeValid <= 1'b1;
        storeAddr <= addr;
        storeSize <= size;
        storeData <= data;
        commitStore <= 1'b0;
        recover <= 1'b0;
        issAddr.push_back(addr);
        issSize.push_back(size);
        issData.push_back(data);
    endtask

    // Region 0 is all cacheable memory, 1 a small hot window, 2 the IO space.
    task automatic randomStore(input int region);
        logic [9:0] addr;
        AccessSize size;
        case (region)
            0: addr = 10'($unsigned($random(seed)) % 960);
            1: addr = 10'h040 + 10'($unsigned($random(seed)) % 32);
            default: addr = IO_START + 10'($unsigned($random(seed)) % 64);
        endcase
        size = AccessSize'(2'($unsigned($random(seed)) % 3));
        driveStore(addr, size, $random(seed));
    endtask

    task automatic driveCommit(input int n);
        @(posedge clk);
        storeValid <= 1'b0;
        recover <= 1'b0;
        commitStore <= 1'b1;
        commitStoreNum <= CommitCount'(n);
        retireModel(n);
    endtask

    // Uncommitted stores are gone from the model once recover is seen.
    task automatic driveRecover();
        @(posedge clk);
        storeValid <= 1'b0;
        commitStore <= 1'b0;
        recover <= 1'b1;
        issAddr.delete();
        issSize.delete();
        issData.delete();
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        driveIdle(1);
        @(negedge clk);
        while (releaseCount != committedCount) begin
            if (waited == DRAIN_TIMEOUT) begin
                $display("Timeout while waiting for committed stores to drain");
                $display("Something failed");
                $finish;
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic checkMemory();
        logic [31:0] expWord;
        for (int w = 0; w < CACHEABLE_WORDS; w++) begin
            @(posedge clk);
            loadAddr <= 10'(w * 4);
            @(negedge clk);
            expWord = {refMem[4*w+3], refMem[4*w+2], refMem[4*w+1], refMem[4*w]};
            checkCount++;
            assert (loadData == expWord) else begin
                errorCount++;
                $display("FAIL %0t: word %h reads %h, expected %h", $time, w, loadData, expWord);
            end
        end
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            refMem[i] = 8'h00;
        end
        rstN = 1'b0;
        storeValid = 1'b0;
        storeAddr = '0;
        storeSize = SIZE_BYTE;
        storeData = '0;
        commitStore = 1'b0;
        commitStoreNum = '0;
        recover = 1'b0;
        loadAddr = '0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        @(negedge clk);
        checkCount++;
        assert (!ioWe && !busyInRecovery && !sqFull) else begin
            errorCount++;
            $display("FAIL %0t: status outputs not idle after reset", $time);
        end

        // Hot window fills a line and then hits it, mixed with misses and IO.
        for (int round = 0; round < 3; round++) begin
            randomStore(1);
            randomStore(1);
            randomStore(0);
            randomStore(2);
            randomStore(1);
            randomStore(0);
            driveIdle(2);
            for (int k = 0; k < 6; k++) begin
                driveCommit(1);
            end
            waitDrain();
        end
        checkMemory();

        // Eight held stores fill the queue; a two-wide burst drains it.
        for (int k = 0; k < 8; k++) begin
            randomStore(k % 3);
        end
        driveIdle(2);
        @(negedge clk);
        checkCount++;
        assert (sqFull) else begin
            errorCount++;
            $display("FAIL %0t: sqFull low with eight stores held", $time);
        end
        for (int k = 0; k < 4; k++) begin
            driveCommit(2);
        end
        waitDrain();
        checkCount++;
        assert (!sqFull) else begin
            errorCount++;
            $display("FAIL %0t: sqFull still high after the drain", $time);
        end

        // Two committed stores survive the recover, the other three do not.
        randomStore(2);
        randomStore(1);
        randomStore(2);
        randomStore(0);
        randomStore(2);
        driveIdle(2);
        driveCommit(2);
        driveRecover();
        waitDrain();
        randomStore(1);
        randomStore(2);
        randomStore(0);
        driveIdle(2);
        driveCommit(2);
        driveCommit(1);
        waitDrain();
        checkMemory();

        driveIdle(4);
        @(negedge clk);
        checkCount++;
        assert (expIoAddr.size() == 0) else begin
            errorCount++;
            $display("FAIL %0t: %0d IO stores never written", $time, expIoAddr.size());
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/StoreSubsystem.sv */
// ----------------------------------------------------------------------
// Store subsystem
// Top level of the store side: allocator, store queue, commit pipeline
// and data cache, with plain ports to the core and the IO port.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module StoreSubsystem import StoreCommitPkg::*; (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire                        storeValid,
    input  wire [ADDR_WIDTH-1:0]       storeAddr,
    input  wire AccessSize             storeSize,
    input  wire [WORD_WIDTH-1:0]       storeData,
    output logic                       sqFull,
    input  wire                        commitStore,
    input  wire CommitCount            commitStoreNum,
    input  wire                        recover,
    output logic                       busyInRecovery,
    output logic                       ioWe,
    output logic [WORD_ADDR_WIDTH-1:0] ioAddr,
    output logic [WORD_WIDTH-1:0]      ioData,
    input  wire [ADDR_WIDTH-1:0]       loadAddr,
    output logic [WORD_WIDTH-1:0]      loadData
);

    logic allocValid;
    StoreEntry allocEntry;
    logic cacheWriteReq;
    StoreEntry cacheWriteEntry;
    logic cacheHit;

    StoreQueueIF sqIf ();

    StoreAllocator i_allocator (
        .clk        (clk),
        .rstN       (rstN),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeSize  (storeSize),
        .storeData  (storeData),
        .allocValid (allocValid),
        .allocEntry (allocEntry)
    );

    StoreQueue i_queue (
        .clk            (clk),
        .rstN           (rstN),
        .allocValid     (allocValid),
        .allocEntry     (allocEntry),
        .commitStore    (commitStore),
        .commitStoreNum (commitStoreNum),
        .recover        (recover),
        .full           (sqFull),
        .sq             (sqIf.queue)
    );

    StoreCommitter i_committer (
        .clk             (clk),
        .rstN            (rstN),
        .recover         (recover),
        .sq              (sqIf.committer),
        .cacheWriteReq   (cacheWriteReq),
        .cacheWriteEntry (cacheWriteEntry),
        .cacheHit        (cacheHit),
        .ioWe            (ioWe),
        .ioAddr          (ioAddr),
        .ioData          (ioData),
        .busyInRecovery  (busyInRecovery)
    );

    DataCache i_cache (
        .clk        (clk),
        .rstN       (rstN),
        .writeReq   (cacheWriteReq),
        .writeEntry (cacheWriteEntry),
        .hit        (cacheHit),
        .loadAddr   (loadAddr),
        .loadData   (loadData)
    );

endmodule

`default_nettype wire

/* design/DataCache.sv */
// ----------------------------------------------------------------------
// Data cache
// Direct-mapped write-through tag array over a word memory. A miss
// fills its line after a fixed latency; loads read memory directly.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module DataCache import StoreCommitPkg::*; (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    writeReq,
    input  wire StoreEntry         writeEntry,
    output logic                   hit,
    input  wire [ADDR_WIDTH-1:0]   loadAddr,
    output logic [WORD_WIDTH-1:0]  loadData
);

    logic [WORD_WIDTH-1:0] mem [MEM_WORD_NUM];

    logic [CACHE_LINE_NUM-1:0] lineValid;
    logic [TAG_WIDTH-1:0] lineTag [CACHE_LINE_NUM];

    logic filling;
    logic [FILL_COUNT_WIDTH-1:0] fillCount;
    logic [LINE_INDEX_WIDTH-1:0] fillIndex;

    logic [LINE_INDEX_WIDTH-1:0] reqIndex;
    logic [TAG_WIDTH-1:0] reqTag;
    logic missStart;

    always_comb begin
        reqIndex = writeEntry.wordAddr[LINE_OFFSET_WIDTH +: LINE_INDEX_WIDTH];
        reqTag = writeEntry.wordAddr[WORD_ADDR_WIDTH-1 -: TAG_WIDTH];
        hit = writeReq && lineValid[reqIndex] && (lineTag[reqIndex] == reqTag);
        // Only one fill at a time.
        missStart = writeReq && !hit && !filling;
        loadData = mem[loadAddr[ADDR_WIDTH-1:BYTE_OFFSET_WIDTH]];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lineValid <= '0;
            filling <= 1'b0;
            fillCount <= '0;
        end else if (filling) begin
            if (fillCount == FILL_COUNT_WIDTH'(1)) begin
                filling <= 1'b0;
                lineValid[fillIndex] <= 1'b1;
            end else begin
                fillCount <= fillCount - 1'b1;
            end
        end else if (missStart) begin
            // The victim line goes invalid until the fill lands.
            filling <= 1'b1;
            fillCount <= FILL_COUNT_WIDTH'(MISS_LATENCY - 1);
            lineValid[reqIndex] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (missStart) begin
            fillIndex <= reqIndex;
            lineTag[reqIndex] <= reqTag;
        end
    end

    initial begin
        for (int i = 0; i < MEM_WORD_NUM; i++) begin
            mem[i] = '0;
        end
    end

    // Write-through of hits, byte lane by byte lane.
    always_ff @(posedge clk) begin
        if (hit) begin
            for (int i = 0; i < BYTE_NUM; i++) begin
                if (writeEntry.byteEn[i]) begin
                    mem[writeEntry.wordAddr][8*i +: 8] <= writeEntry.data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/StoreCommitter.sv */
// ----------------------------------------------------------------------
// Store committer
// Two-stage commit pipeline. The tag stage checks and writes the cache,
// the data stage releases the queue head and drives IO stores.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module StoreCommitter import StoreCommitPkg::*; (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire                       recover,
    StoreQueueIF.committer            sq,
    output logic                      cacheWriteReq,
    output StoreEntry                 cacheWriteEntry,
    input  wire                       cacheHit,
    output logic                      ioWe,
    output logic [WORD_ADDR_WIDTH-1:0] ioAddr,
    output logic [WORD_WIDTH-1:0]     ioData,
    output logic                      busyInRecovery
);

    CommitPhase phase;
    CommitPhase nextPhase;

    // Pipeline registers.
    logic tagValid;
    StoreEntry tagEntry;
    logic dataValid;
    StoreEntry dataEntry;

    SqCount inFlightNum;
    SqCount unfinishedNum;
    logic stallTag;
    logic issue;

    // Recovery lasts one cycle while the queue truncates itself.
    always_comb begin
        case (phase)
            PHASE_COMMIT: begin
                nextPhase = recover ? PHASE_RECOVER : PHASE_COMMIT;
            end
            default: begin
                nextPhase = PHASE_COMMIT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= PHASE_COMMIT;
        end else begin
            phase <= nextPhase;
        end
    end

    // Queue stage.
    // Committed stores not yet in the pipeline wait behind the in-flight ones.
    always_comb begin
        inFlightNum = SqCount'(tagValid) + SqCount'(dataValid);
        unfinishedNum = sq.pendingNum - inFlightNum;
        issue = (phase == PHASE_COMMIT) && sq.headValid && (unfinishedNum != '0);
        busyInRecovery = (phase == PHASE_RECOVER);
    end

    // Tag stage.
    // A cacheable store holds here until the cache reports a hit.
    always_comb begin
        cacheWriteReq = tagValid && !tagEntry.isIO;
        cacheWriteEntry = tagEntry;
        stallTag = tagValid && !tagEntry.isIO && !cacheHit;
    end

    // Data stage.
    always_comb begin
        sq.releaseHead = dataValid;
        ioWe = dataValid && dataEntry.isIO;
        ioAddr = dataEntry.wordAddr;
        ioData = dataEntry.data;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tagValid <= 1'b0;
            dataValid <= 1'b0;
        end else begin
            if (!stallTag) begin
                tagValid <= issue;
            end
            dataValid <= tagValid && !stallTag;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallTag) begin
            tagEntry <= sq.headEntry[inFlightNum];
        end
        dataEntry <= tagEntry;
    end

endmodule

`default_nettype wire

/* design/StoreQueue.sv */
// ----------------------------------------------------------------------
// Store queue
// Circular buffer of stores with head, commit and tail pointers. Commit
// marks the oldest entries, release frees the head, recovery truncates.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module StoreQueue import StoreCommitPkg::*; (
    input  wire               clk,
    input  wire               rstN,
    input  wire               allocValid,
    input  wire StoreEntry    allocEntry,
    input  wire               commitStore,
    input  wire CommitCount   commitStoreNum,
    input  wire               recover,
    output logic              full,
    StoreQueueIF.queue        sq
);

    // Pointers carry one wrap bit above the index, so head == tail is empty
    // and a distance of SQ_ENTRY_NUM is full.
    SqCount headPtr;
    SqCount commitPtr;
    SqCount tailPtr;
    SqCount nextCommitPtr;
    SqCount usedNum;
    logic allocAccept;

    StoreEntry entries [SQ_ENTRY_NUM];

    always_comb begin
        usedNum = tailPtr - headPtr;
        full = (usedNum == SqCount'(SQ_ENTRY_NUM));
        allocAccept = allocValid && !full && !recover;

        nextCommitPtr = commitPtr;
        if (commitStore) begin
            nextCommitPtr = commitPtr + SqCount'(commitStoreNum);
        end
    end

    // Head-side view for the commit pipeline.
    always_comb begin
        sq.headValid = (usedNum != '0);
        sq.pendingNum = commitPtr - headPtr;
        for (int i = 0; i < SQ_WINDOW_NUM; i++) begin
            sq.headEntry[i] = entries[SqIndex'(headPtr + SqCount'(i))];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            commitPtr <= '0;
            tailPtr <= '0;
        end else begin
            if (sq.releaseHead) begin
                headPtr <= headPtr + 1'b1;
            end

            commitPtr <= nextCommitPtr;

            // Recovery drops everything younger than the commit boundary,
            // counting any commit that lands in the same cycle.
            if (recover) begin
                tailPtr <= nextCommitPtr;
            end else if (allocAccept) begin
                tailPtr <= tailPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocAccept) begin
            entries[SqIndex'(tailPtr)] <= allocEntry;
        end
    end

endmodule

`default_nettype wire

/* design/StoreAllocator.sv */
// ----------------------------------------------------------------------
// Store allocator
// Registers one store request per cycle and turns its size and address
// into an aligned word with byte enables and an IO flag.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module StoreAllocator import StoreCommitPkg::*; (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    storeValid,
    input  wire [ADDR_WIDTH-1:0]   storeAddr,
    input  wire AccessSize         storeSize,
    input  wire [WORD_WIDTH-1:0]   storeData,
    output logic                   allocValid,
    output StoreEntry              allocEntry
);

    logic [BYTE_OFFSET_WIDTH-1:0] lane;
    logic [BYTE_NUM-1:0] sizeMask;
    logic [WORD_WIDTH-1:0] bitMask;
    logic [BYTE_NUM-1:0] byteEn;
    logic [WORD_WIDTH-1:0] laneData;

    always_comb begin
        lane = storeAddr[BYTE_OFFSET_WIDTH-1:0];
        // Halves align down to an even byte, words to the word boundary.
        case (storeSize)
            SIZE_BYTE: begin
                sizeMask = BYTE_NUM'(1);
            end
            SIZE_HALF: begin
                sizeMask = BYTE_NUM'(3);
                lane[0] = 1'b0;
            end
            default: begin
                sizeMask = '1;
                lane = '0;
            end
        endcase

        // Unused source bytes are cleared before the shift.
        for (int i = 0; i < BYTE_NUM; i++) begin
            bitMask[8*i +: 8] = {8{sizeMask[i]}};
        end

        byteEn = sizeMask << lane;
        laneData = (storeData & bitMask) << (8 * lane);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            allocValid <= 1'b0;
        end else begin
            allocValid <= storeValid;
        end
    end

    always_ff @(posedge clk) begin
        allocEntry.wordAddr <= storeAddr[ADDR_WIDTH-1:BYTE_OFFSET_WIDTH];
        allocEntry.data <= laneData;
        allocEntry.byteEn <= byteEn;
        allocEntry.isIO <= (storeAddr >= IO_BASE);
    end

endmodule

`default_nettype wire

/* design/StoreQueueIF.sv */
// ----------------------------------------------------------------------
// Store queue to committer link
// Carries the oldest queue entries and the committed count to the
// commit pipeline, and the head release strobe back.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface StoreQueueIF import StoreCommitPkg::*; ();

    // High while the queue holds at least one entry.
    logic headValid;

    // Entry i is the one i places behind the head.
    StoreEntry [SQ_WINDOW_NUM-1:0] headEntry;

    // Committed entries that have not been released yet.
    SqCount pendingNum;

    // One-cycle strobe that frees exactly the head entry.
    logic releaseHead;

    modport queue (
        output headValid,
        output headEntry,
        output pendingNum,
        input  releaseHead
    );

    modport committer (
        input  headValid,
        input  headEntry,
        input  pendingNum,
        output releaseHead
    );

endinterface

`default_nettype wire

/* design/StoreCommitPkg.sv */
// ----------------------------------------------------------------------
// Store commit package
// Sizes, widths, enums and the store queue entry shared by the store
// side of the load/store unit.
// ----------------------------------------------------------------------
`default_nettype none

package StoreCommitPkg;

    // Address space and data word.
    localparam int ADDR_WIDTH = 10;
    localparam int WORD_WIDTH = 32;
    localparam int BYTE_NUM = WORD_WIDTH / 8;
    localparam int BYTE_OFFSET_WIDTH = $clog2(BYTE_NUM);
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - BYTE_OFFSET_WIDTH;
    localparam int MEM_WORD_NUM = 2 ** WORD_ADDR_WIDTH;

    // Store queue and commit pipeline.
    localparam int SQ_ENTRY_NUM = 8;
    localparam int COMMIT_WIDTH = 2;
    // The head plus the two stores that the tag and data stages can hold.
    localparam int SQ_WINDOW_NUM = 3;

    // Data cache geometry and miss timing.
    localparam int LINE_WORD_NUM = 4;
    localparam int CACHE_LINE_NUM = 8;
    localparam int LINE_OFFSET_WIDTH = $clog2(LINE_WORD_NUM);
    localparam int LINE_INDEX_WIDTH = $clog2(CACHE_LINE_NUM);
    localparam int TAG_WIDTH = WORD_ADDR_WIDTH - LINE_INDEX_WIDTH - LINE_OFFSET_WIDTH;
    localparam int MISS_LATENCY = 4;
    localparam int FILL_COUNT_WIDTH = $clog2(MISS_LATENCY + 1);

    // Byte addresses from here upward belong to the IO port.
    localparam logic [ADDR_WIDTH-1:0] IO_BASE = 10'h3C0;

    typedef logic [$clog2(SQ_ENTRY_NUM)-1:0] SqIndex;
    typedef logic [$clog2(SQ_ENTRY_NUM + 1)-1:0] SqCount;
    typedef logic [$clog2(COMMIT_WIDTH + 1)-1:0] CommitCount;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } AccessSize;

    typedef enum logic {
        PHASE_COMMIT = 1'b0,
        PHASE_RECOVER = 1'b1
    } CommitPhase;

    typedef struct packed {
        logic [WORD_ADDR_WIDTH-1:0] wordAddr;
        logic [WORD_WIDTH-1:0] data;
        logic [BYTE_NUM-1:0] byteEn;
        logic isIO;
    } StoreEntry;

endpackage

`default_nettype wire
